/* design/mesh_pkg.sv */
package mesh_pkg;

  // coordinate widths; row num_tiles_y addresses the south exit
  localparam int mesh_x_width    = 4;
  localparam int mesh_y_width    = 4;

  localparam int mesh_addr_width = 16; // word address inside a bank
  localparam int mesh_data_width = 32;

  typedef enum logic [1:0]
  {
    store = 2'd0,  // write data to addr
    load  = 2'd1,  // read addr, answer with resp
    resp  = 2'd2   // load data on its way to the south edge
  } mesh_op_e;

  // 62 bits total
  typedef struct packed
  {
    mesh_op_e                   op;
    logic [mesh_x_width-1:0]    dest_x;
    logic [mesh_y_width-1:0]    dest_y;
    logic [mesh_x_width-1:0]    ret_x;   // exit column for a load response
    logic [mesh_addr_width-1:0] addr;
    logic [mesh_data_width-1:0] data;
  } mesh_packet_t;

  // router port index
  typedef enum logic [2:0]
  {
    P = 3'd0,
    W = 3'd1,
    E = 3'd2,
    N = 3'd3,
    S = 3'd4
  } mesh_dir_e;

  // stores here go to the tile status port, never to the bank
  localparam logic [mesh_addr_width-1:0] mesh_status_addr = 16'hFFFF;

endpackage

/* design/mesh_fifo.sv */
`timescale 1ns/1ns

module mesh_fifo import mesh_pkg::*;
#(
  parameter int els_p = 2
)
(
  input  logic         clk,
  input  logic         reset,
  input  mesh_packet_t data_i,
  input  logic         valid_i,
  input  logic         yumi_i,
  output logic         ready_o,
  output mesh_packet_t data_o,
  output logic         valid_o
);

  localparam int ptr_w_lp = (els_p > 1) ? $clog2(els_p) : 1;

  mesh_packet_t        mem [els_p];
  logic [ptr_w_lp-1:0] rd_ptr_r;
  logic [ptr_w_lp-1:0] wr_ptr_r;
  logic [ptr_w_lp-1:0] rd_ptr_n;
  logic [ptr_w_lp-1:0] wr_ptr_n;
  logic                full_r;
  logic                empty_r;
  logic                push;
  logic                pop;

  assign ready_o = ~full_r;
  assign valid_o = ~empty_r;
  assign data_o  = mem[rd_ptr_r];

  assign push = valid_i & ready_o;
  assign pop  = yumi_i;  // consumer only takes a valid head

  // pointers wrap at els_p, which need not be a power of two
  assign rd_ptr_n = (rd_ptr_r == ptr_w_lp'(els_p - 1)) ? '0 : rd_ptr_r + 1'b1;
  assign wr_ptr_n = (wr_ptr_r == ptr_w_lp'(els_p - 1)) ? '0 : wr_ptr_r + 1'b1;

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr_r] <= data_i;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      full_r   <= 1'b0;
      empty_r  <= 1'b1;
    end
    else
    begin
      if (push)
        wr_ptr_r <= wr_ptr_n;
      if (pop)
        rd_ptr_r <= rd_ptr_n;
      if (push && !pop)
      begin
        empty_r <= 1'b0;
        full_r  <= (wr_ptr_n == rd_ptr_r);
      end
      else if (pop && !push)
      begin
        full_r  <= 1'b0;
        empty_r <= (rd_ptr_n == wr_ptr_r);
      end
    end
  end

endmodule

/* design/mesh_router.sv */
`timescale 1ns/1ns

module mesh_router import mesh_pkg::*;
#(
  parameter int fifo_els_p    = 2,
  parameter int num_tiles_y_p = 2
)
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic [mesh_x_width-1:0] my_x_i,
  input  logic [mesh_y_width-1:0] my_y_i,

  input  mesh_packet_t [S:P]      packet_i,
  input  logic [S:P]              valid_i,
  input  logic [S:P]              ready_i,

  output logic [S:P]              ready_o,
  output mesh_packet_t [S:P]      packet_o,
  output logic [S:P]              valid_o
);

  // row just below the array, where responses leave
  localparam logic [mesh_y_width-1:0] exit_row_lp = mesh_y_width'(num_tiles_y_p);

  mesh_packet_t [S:P] head;
  logic [S:P]         head_v;
  logic [S:P]         yumi;
  mesh_dir_e          route [5];
  logic [2:0]         gnt [5];
  logic [2:0]         last_r [5];      // last input served per output
  logic [2:0]         hold_idx_r [5];
  logic [S:P]         hold_r;          // output offered but not taken last cycle

  for (genvar d = 0; d < 5; d++)
  begin : port
    mesh_fifo #(
      .els_p(fifo_els_p)
    ) fifo (
      .clk    (clk),
      .reset  (reset),
      .data_i (packet_i[d]),
      .valid_i(valid_i[d]),
      .yumi_i (yumi[d]),
      .ready_o(ready_o[d]),
      .data_o (head[d]),
      .valid_o(head_v[d])
    );
  end

  // dimension order: X first, then Y
  always_comb
  begin
    for (int i = 0; i < 5; i++)
    begin
      if (head[i].dest_x > my_x_i)
        route[i] = E;
      else if (head[i].dest_x < my_x_i)
        route[i] = W;
      else if (head[i].dest_y >= exit_row_lp || head[i].dest_y > my_y_i)
        route[i] = S;  // heading down, or leaving through the south edge
      else if (head[i].dest_y < my_y_i)
        route[i] = N;
      else
        route[i] = P;
    end
  end

  // round-robin per output, starting after the last served input
  always_comb
  begin
    logic found;
    int   idx;
    yumi = '0;
    for (int o = 0; o < 5; o++)
    begin
      found  = 1'b0;
      gnt[o] = last_r[o];
      for (int k = 1; k <= 5; k++)
      begin
        idx = (int'(last_r[o]) + k) % 5;
        if (!found && head_v[idx] && route[idx] == mesh_dir_e'(o))
        begin
          found  = 1'b1;
          gnt[o] = 3'(idx);
        end
      end
      // a stalled offer stays with the same input until it is taken
      if (hold_r[o])
      begin
        found  = 1'b1;
        gnt[o] = hold_idx_r[o];
      end
      valid_o[o]  = found;
      packet_o[o] = head[gnt[o]];
      if (found && ready_i[o])
        yumi[gnt[o]] = 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      hold_r <= '0;
      for (int o = 0; o < 5; o++)
        last_r[o] <= 3'd4;  // P gets first turn
    end
    else
    begin
      for (int o = 0; o < 5; o++)
      begin
        hold_r[o] <= valid_o[o] & ~ready_i[o];
        if (valid_o[o] && ready_i[o])
          last_r[o] <= gnt[o];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    for (int o = 0; o < 5; o++)
      hold_idx_r[o] <= gnt[o];
  end

endmodule

/* design/mesh_tile.sv */
`timescale 1ns/1ns

module mesh_tile import mesh_pkg::*;
#(
  parameter int bank_words_p  = 256,
  parameter int fifo_els_p    = 2,
  parameter int num_tiles_y_p = 2
)
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic [mesh_x_width-1:0]    my_x_i,
  input  logic [mesh_y_width-1:0]    my_y_i,

  input  mesh_packet_t               w_packet_i,
  input  logic                       w_valid_i,
  output logic                       w_ready_o,
  output mesh_packet_t               w_packet_o,
  output logic                       w_valid_o,
  input  logic                       w_ready_i,

  input  mesh_packet_t               e_packet_i,
  input  logic                       e_valid_i,
  output logic                       e_ready_o,
  output mesh_packet_t               e_packet_o,
  output logic                       e_valid_o,
  input  logic                       e_ready_i,

  input  mesh_packet_t               n_packet_i,
  input  logic                       n_valid_i,
  output logic                       n_ready_o,
  output mesh_packet_t               n_packet_o,
  output logic                       n_valid_o,
  input  logic                       n_ready_i,

  input  mesh_packet_t               s_packet_i,
  input  logic                       s_valid_i,
  output logic                       s_ready_o,
  output mesh_packet_t               s_packet_o,
  output logic                       s_valid_o,
  input  logic                       s_ready_i,

  output logic                       status_valid_o,
  output logic [mesh_data_width-1:0] status_data_o
);

  localparam int idx_w_lp = $clog2(bank_words_p);

  mesh_packet_t [S:P]         r_pkt_i;
  mesh_packet_t [S:P]         r_pkt_o;
  logic [S:P]                 r_v_i;
  logic [S:P]                 r_v_o;
  logic [S:P]                 r_rdy_i;
  logic [S:P]                 r_rdy_o;
  logic [mesh_data_width-1:0] bank [bank_words_p];
  mesh_packet_t               req;
  mesh_packet_t               resp_r;
  logic                       resp_v_r;
  logic                       status_v_r;
  logic [mesh_data_width-1:0] status_r;
  logic                       deq;
  logic                       is_status;
  logic [idx_w_lp-1:0]        bank_idx;

  assign r_pkt_i = {s_packet_i, n_packet_i, e_packet_i, w_packet_i, resp_r};
  assign r_v_i   = {s_valid_i, n_valid_i, e_valid_i, w_valid_i, resp_v_r};
  assign r_rdy_i = {s_ready_i, n_ready_i, e_ready_i, w_ready_i, ~resp_v_r};

  assign {s_packet_o, n_packet_o, e_packet_o, w_packet_o} = r_pkt_o[S:W];
  assign {s_valid_o, n_valid_o, e_valid_o, w_valid_o}     = r_v_o[S:W];
  assign {s_ready_o, n_ready_o, e_ready_o, w_ready_o}     = r_rdy_o[S:W];

  mesh_router #(
    .fifo_els_p   (fifo_els_p),
    .num_tiles_y_p(num_tiles_y_p)
  ) router (
    .clk     (clk),
    .reset   (reset),
    .my_x_i  (my_x_i),
    .my_y_i  (my_y_i),
    .packet_i(r_pkt_i),
    .valid_i (r_v_i),
    .ready_i (r_rdy_i),
    .ready_o (r_rdy_o),
    .packet_o(r_pkt_o),
    .valid_o (r_v_o)
  );

  // local port; nothing is taken while a response is pending
  assign req       = r_pkt_o[P];
  assign deq       = r_v_o[P] & ~resp_v_r;
  assign is_status = (req.addr == mesh_status_addr);
  assign bank_idx  = req.addr[idx_w_lp-1:0];

  assign status_valid_o = status_v_r;
  assign status_data_o  = status_r;

  always_ff @(posedge clk)
  begin
    if (deq && req.op == store && !is_status)
      bank[bank_idx] <= req.data;
    if (deq && req.op == store && is_status)
      status_r <= req.data;
    if (deq && req.op == load)
      resp_r <= '{op: resp, dest_x: req.ret_x, dest_y: mesh_y_width'(num_tiles_y_p),
                  ret_x: req.ret_x, addr: req.addr, data: bank[bank_idx]};
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      resp_v_r   <= 1'b0;
      status_v_r <= 1'b0;
    end
    else
    begin
      status_v_r <= deq & (req.op == store) & is_status;
      if (deq && req.op == load)
        resp_v_r <= 1'b1;
      else if (r_rdy_o[P])
        resp_v_r <= 1'b0;  // router took the response
    end
  end

endmodule

/* design/mesh_tile_array.sv */
`timescale 1ns/1ns

module mesh_tile_array import mesh_pkg::*;
#(
  parameter int num_tiles_x_p = 2,
  parameter int num_tiles_y_p = 2,
  parameter int bank_words_p  = 256,
  parameter int fifo_els_p    = 2
)
(
  input  logic         clk,
  input  logic         reset,
  input  mesh_packet_t in_packet_i,
  input  logic         in_valid_i,
  output logic         in_ready_o,

  output mesh_packet_t [num_tiles_x_p-1:0] south_packet_o,
  output logic [num_tiles_x_p-1:0]         south_valid_o,

  output logic [num_tiles_y_p-1:0][num_tiles_x_p-1:0]                      status_valid_o,
  output logic [num_tiles_y_p-1:0][num_tiles_x_p-1:0][mesh_data_width-1:0] status_data_o
);

  // link signals seen from each tile, indexed [row][col][dir]
  mesh_packet_t [num_tiles_y_p-1:0][num_tiles_x_p-1:0][S:W] lnk_pkt_i;
  mesh_packet_t [num_tiles_y_p-1:0][num_tiles_x_p-1:0][S:W] lnk_pkt_o;
  logic [num_tiles_y_p-1:0][num_tiles_x_p-1:0][S:W]         lnk_v_i;
  logic [num_tiles_y_p-1:0][num_tiles_x_p-1:0][S:W]         lnk_v_o;
  logic [num_tiles_y_p-1:0][num_tiles_x_p-1:0][S:W]         lnk_rdy_i;
  logic [num_tiles_y_p-1:0][num_tiles_x_p-1:0][S:W]         lnk_rdy_o;

  for (genvar y = 0; y < num_tiles_y_p; y++)
  begin : row
    for (genvar x = 0; x < num_tiles_x_p; x++)
    begin : col
      mesh_tile #(
        .bank_words_p (bank_words_p),
        .fifo_els_p   (fifo_els_p),
        .num_tiles_y_p(num_tiles_y_p)
      ) tile (
        .clk           (clk),
        .reset         (reset),
        .my_x_i        (mesh_x_width'(x)),
        .my_y_i        (mesh_y_width'(y)),
        .w_packet_i    (lnk_pkt_i[y][x][W]),
        .w_valid_i     (lnk_v_i[y][x][W]),
        .w_ready_o     (lnk_rdy_o[y][x][W]),
        .w_packet_o    (lnk_pkt_o[y][x][W]),
        .w_valid_o     (lnk_v_o[y][x][W]),
        .w_ready_i     (lnk_rdy_i[y][x][W]),
        .e_packet_i    (lnk_pkt_i[y][x][E]),
        .e_valid_i     (lnk_v_i[y][x][E]),
        .e_ready_o     (lnk_rdy_o[y][x][E]),
        .e_packet_o    (lnk_pkt_o[y][x][E]),
        .e_valid_o     (lnk_v_o[y][x][E]),
        .e_ready_i     (lnk_rdy_i[y][x][E]),
        .n_packet_i    (lnk_pkt_i[y][x][N]),
        .n_valid_i     (lnk_v_i[y][x][N]),
        .n_ready_o     (lnk_rdy_o[y][x][N]),
        .n_packet_o    (lnk_pkt_o[y][x][N]),
        .n_valid_o     (lnk_v_o[y][x][N]),
        .n_ready_i     (lnk_rdy_i[y][x][N]),
        .s_packet_i    (lnk_pkt_i[y][x][S]),
        .s_valid_i     (lnk_v_i[y][x][S]),
        .s_ready_o     (lnk_rdy_o[y][x][S]),
        .s_packet_o    (lnk_pkt_o[y][x][S]),
        .s_valid_o     (lnk_v_o[y][x][S]),
        .s_ready_i     (lnk_rdy_i[y][x][S]),
        .status_valid_o(status_valid_o[y][x]),
        .status_data_o (status_data_o[y][x])
      );

      if (x > 0)
      begin : w_link
        assign lnk_pkt_i[y][x][W] = lnk_pkt_o[y][x-1][E];
        assign lnk_v_i[y][x][W]   = lnk_v_o[y][x-1][E];
        assign lnk_rdy_i[y][x][W] = lnk_rdy_o[y][x-1][E];
      end
      else if (y == 0)
      begin : w_inject
        assign lnk_pkt_i[y][x][W] = in_packet_i;
        assign lnk_v_i[y][x][W]   = in_valid_i;
        assign lnk_rdy_i[y][x][W] = 1'b1;  // westward output discarded
        assign in_ready_o         = lnk_rdy_o[y][x][W];
      end
      else
      begin : w_stub
        assign lnk_pkt_i[y][x][W] = '0;
        assign lnk_v_i[y][x][W]   = 1'b0;
        assign lnk_rdy_i[y][x][W] = 1'b1;
      end

      if (x < num_tiles_x_p - 1)
      begin : e_link
        assign lnk_pkt_i[y][x][E] = lnk_pkt_o[y][x+1][W];
        assign lnk_v_i[y][x][E]   = lnk_v_o[y][x+1][W];
        assign lnk_rdy_i[y][x][E] = lnk_rdy_o[y][x+1][W];
      end
      else
      begin : e_stub
        assign lnk_pkt_i[y][x][E] = '0;
        assign lnk_v_i[y][x][E]   = 1'b0;
        assign lnk_rdy_i[y][x][E] = 1'b1;
      end

      if (y > 0)
      begin : n_link
        assign lnk_pkt_i[y][x][N] = lnk_pkt_o[y-1][x][S];
        assign lnk_v_i[y][x][N]   = lnk_v_o[y-1][x][S];
        assign lnk_rdy_i[y][x][N] = lnk_rdy_o[y-1][x][S];
      end
      else
      begin : n_stub
        assign lnk_pkt_i[y][x][N] = '0;
        assign lnk_v_i[y][x][N]   = 1'b0;
        assign lnk_rdy_i[y][x][N] = 1'b1;
      end

      if (y < num_tiles_y_p - 1)
      begin : s_link
        assign lnk_pkt_i[y][x][S] = lnk_pkt_o[y+1][x][N];
        assign lnk_v_i[y][x][S]   = lnk_v_o[y+1][x][N];
        assign lnk_rdy_i[y][x][S] = lnk_rdy_o[y+1][x][N];
      end
      else
      begin : s_exit
        // south edge always accepts, so each exit is a one-cycle strobe
        assign lnk_pkt_i[y][x][S] = '0;
        assign lnk_v_i[y][x][S]   = 1'b0;
        assign lnk_rdy_i[y][x][S] = 1'b1;
        assign south_packet_o[x]  = lnk_pkt_o[y][x][S];
        assign south_valid_o[x]   = lnk_v_o[y][x][S];
      end
    end
  end

endmodule

/* sim/mesh_properties.sv */
`timescale 1ns/1ns

module mesh_properties import mesh_pkg::*;
#(
  parameter int num_tiles_x_p = 2,
  parameter int num_tiles_y_p = 2
)
(
  input logic                                        clk,
  input logic                                        reset,
  input mesh_packet_t [num_tiles_x_p-1:0]            south_packet_o,
  input logic [num_tiles_x_p-1:0]                    south_valid_o,
  input logic [num_tiles_y_p-1:0][num_tiles_x_p-1:0] status_valid_o
);

  // strobes are registered, so they read low from one edge into reset onward
  a_quiet_in_reset: assert property (@(posedge clk)
    $past(reset) |-> (south_valid_o == '0 && status_valid_o == '0))
    else $error("strobe seen while reset was applied");

  for (genvar c = 0; c < num_tiles_x_p; c++)
  begin : col
    a_resp_op: assert property (@(posedge clk) disable iff (reset)
      south_valid_o[c] |-> south_packet_o[c].op == resp)
      else $error("south packet at column %0d is not a response", c);

    a_resp_col: assert property (@(posedge clk) disable iff (reset)
      south_valid_o[c] |-> south_packet_o[c].dest_x == mesh_x_width'(c))
      else $error("south packet at column %0d names another column", c);
  end

endmodule

bind mesh_tile_array mesh_properties #(
  .num_tiles_x_p(num_tiles_x_p),
  .num_tiles_y_p(num_tiles_y_p)
) props (
  .clk           (clk),
  .reset         (reset),
  .south_packet_o(south_packet_o),
  .south_valid_o (south_valid_o),
  .status_valid_o(status_valid_o)
);

/* sim/tb_mesh_tile_array.sv */
`timescale 1ns/1ns

module tb_mesh_tile_array import mesh_pkg::*;
();

  localparam int num_x_lp         = 2;
  localparam int num_y_lp         = 2;
  localparam int bank_words_lp    = 256;
  localparam int fifo_els_lp      = 2;
  localparam int hs_timeout_lp    = 200;   // cycles for one handshake
  localparam int drain_timeout_lp = 2000;

  logic                                                   clk;
  logic                                                   reset;
  mesh_packet_t                                           in_packet;
  logic                                                   in_valid;
  logic                                                   in_ready;
  mesh_packet_t [num_x_lp-1:0]                            south_packet;
  logic [num_x_lp-1:0]                                    south_valid;
  logic [num_y_lp-1:0][num_x_lp-1:0]                      status_valid;
  logic [num_y_lp-1:0][num_x_lp-1:0][mesh_data_width-1:0] status_data;

  logic [31:0]  lcg_state;
  logic [31:0]  model_mem [int];                  // keyed by tile and address
  mesh_packet_t resp_q [num_x_lp][$];             // expected responses per exit column
  logic [31:0]  status_q [num_x_lp*num_y_lp][$];
  int           ready_low_count;

  mesh_tile_array #(
    .num_tiles_x_p(num_x_lp),
    .num_tiles_y_p(num_y_lp),
    .bank_words_p (bank_words_lp),
    .fifo_els_p   (fifo_els_lp)
  ) UUT (
    .clk           (clk),
    .reset         (reset),
    .in_packet_i   (in_packet),
    .in_valid_i    (in_valid),
    .in_ready_o    (in_ready),
    .south_packet_o(south_packet),
    .south_valid_o (south_valid),
    .status_valid_o(status_valid),
    .status_data_o (status_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {16'd0, lcg_state[31:16]};  // low bits of an lcg cycle too fast
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi[15:0], lo[15:0]};
  endfunction

  function automatic int tile_key(input int x, input int y, input logic [15:0] addr);
    return (y * num_x_lp + x) * 65536 + int'(addr);
  endfunction

  function automatic mesh_packet_t make_packet(input mesh_op_e op, input int x, input int y,
                                               input int ret_col, input logic [15:0] addr,
                                               input logic [31:0] data);
    mesh_packet_t p;
    p.op     = op;
    p.dest_x = mesh_x_width'(x);
    p.dest_y = mesh_y_width'(y);
    p.ret_x  = mesh_x_width'(ret_col);
    p.addr   = addr;
    p.data   = data;
    return p;
  endfunction

  // a load answers from the row below the array, at its return column
  function automatic mesh_packet_t expected_resp(input int x, input int y,
                                                 input logic [15:0] addr, input int ret_col);
    mesh_packet_t p;
    p.op     = resp;
    p.dest_x = mesh_x_width'(ret_col);
    p.dest_y = mesh_y_width'(num_y_lp);
    p.ret_x  = mesh_x_width'(ret_col);
    p.addr   = addr;
    p.data   = model_mem[tile_key(x, y, addr)];
    return p;
  endfunction

  task automatic check_value(input logic [63:0] got, input logic [63:0] want,
                             input string what);
    if (got !== want)
    begin
      $display("FAIL at %0t ns: %s, got %0h, expected %0h", $time, what, got, want);
      $display("Simulation failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("ERROR at %0t ns: %s", $time, why);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  // called 1 ns after a rising edge, returns 1 ns after the accepting edge
  task automatic send_packet(input mesh_packet_t p);
    int  waited;
    logic accepted;
    in_packet = p;
    in_valid  = 1'b1;
    waited    = 0;
    accepted  = 1'b0;
    while (!accepted)
    begin
      @(negedge clk);
      accepted = (in_ready === 1'b1);  // ready moves only on edges
      if (!accepted)
        ready_low_count++;
      @(posedge clk);
      #1;
      waited++;
      if (!accepted && waited > hs_timeout_lp)
        abort_run("injection port never accepted a packet");
    end
    in_valid = 1'b0;
  endtask

  task automatic store_word(input int x, input int y, input logic [15:0] addr,
                            input logic [31:0] data);
    if (addr == mesh_status_addr)
      status_q[y * num_x_lp + x].push_back(data);
    else
      model_mem[tile_key(x, y, addr)] = data;
    send_packet(make_packet(store, x, y, 0, addr, data));
  endtask

  task automatic load_word(input int x, input int y, input logic [15:0] addr,
                           input int ret_col);
    resp_q[ret_col].push_back(expected_resp(x, y, addr, ret_col));
    send_packet(make_packet(load, x, y, ret_col, addr, 32'd0));
  endtask

  function automatic int pending_count();
    int n;
    n = 0;
    for (int c = 0; c < num_x_lp; c++)
      n += resp_q[c].size();
    for (int t = 0; t < num_x_lp * num_y_lp; t++)
      n += status_q[t].size();
    return n;
  endfunction

  task automatic drain_queues();
    int waited;
    waited = 0;
    while (pending_count() != 0)
    begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > drain_timeout_lp)
        abort_run("responses or status strobes still missing after the drain timeout");
    end
  endtask

  // outputs are sampled mid-cycle, where they are stable
  initial
  begin : compare
    mesh_packet_t want;
    forever
    begin
      @(negedge clk);
      for (int c = 0; c < num_x_lp; c++)
      begin
        if (south_valid[c] === 1'b1)
        begin
          if (resp_q[c].size() == 0)
            abort_run($sformatf("unexpected south strobe at column %0d", c));
          else
          begin
            want = resp_q[c].pop_front();
            check_value(south_packet[c].op, want.op, "response opcode");
            check_value(south_packet[c].dest_x, want.dest_x, "exit column");
            check_value(south_packet[c].dest_y, want.dest_y, "exit row");
            check_value(south_packet[c].ret_x, want.ret_x, "response return column");
            check_value(south_packet[c].addr, want.addr, "response address");
            check_value(south_packet[c].data, want.data, "response data");
          end
        end
      end
      for (int y = 0; y < num_y_lp; y++)
        for (int x = 0; x < num_x_lp; x++)
          if (status_valid[y][x] === 1'b1)
          begin
            if (status_q[y * num_x_lp + x].size() == 0)
              abort_run($sformatf("unexpected status strobe from tile (%0d,%0d)", x, y));
            else
              check_value(status_data[y][x], status_q[y * num_x_lp + x].pop_front(),
                          $sformatf("status data of tile (%0d,%0d)", x, y));
          end
    end
  end

  initial
  begin : main
    logic [15:0] addr_list [6];
    logic [15:0] a;
    int          waited;
    lcg_state       = 32'd82767;
    reset           = 1'b1;
    in_valid        = 1'b0;
    in_packet       = '0;
    ready_low_count = 0;
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;

    // quiet after reset, injection port opens
    waited = 0;
    while (in_ready !== 1'b1)
    begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > hs_timeout_lp)
        abort_run("in_ready_o did not rise after reset");
    end
    repeat (10) @(posedge clk);
    #1;

    // stores then loads on every tile, one tile in flight at a time
    for (int ty = 0; ty < num_y_lp; ty++)
      for (int tx = 0; tx < num_x_lp; tx++)
      begin
        for (int i = 0; i < 6; i++)
        begin
          addr_list[i] = 16'(lcg_next() % bank_words_lp);
          store_word(tx, ty, addr_list[i], rand_word());
        end
        for (int i = 0; i < 6; i++)
          load_word(tx, ty, addr_list[i], int'(lcg_next() % num_x_lp));
        drain_queues();
      end

    // overwrite, newer value must come back
    a = 16'(lcg_next() % bank_words_lp);
    store_word(1, 0, a, 32'h1111_0001);
    store_word(1, 0, a, 32'h2222_0002);
    load_word(1, 0, a, 0);
    drain_queues();

    // status port: finished, then a failure code per tile
    for (int ty = 0; ty < num_y_lp; ty++)
      for (int tx = 0; tx < num_x_lp; tx++)
        store_word(tx, ty, mesh_status_addr, 32'd1);
    drain_queues();
    for (int ty = 0; ty < num_y_lp; ty++)
      for (int tx = 0; tx < num_x_lp; tx++)
        store_word(tx, ty, mesh_status_addr, 32'hE000_0002 + 32'(ty * num_x_lp + tx));
    drain_queues();

    // load burst at the far corner should back up to the injection port
    for (int i = 0; i < 8; i++)
      store_word(num_x_lp - 1, num_y_lp - 1, 16'h0040 + 16'(i), rand_word());
    ready_low_count = 0;
    for (int i = 0; i < 40; i++)
      load_word(num_x_lp - 1, num_y_lp - 1, 16'h0040 + 16'(lcg_next() % 8),
                int'(lcg_next() % num_x_lp));
    if (ready_low_count == 0)
      abort_run("in_ready_o never dropped during the load burst");
    drain_queues();

    repeat (10) @(posedge clk);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* filelist.f */
design/mesh_pkg.sv
design/mesh_fifo.sv
design/mesh_router.sv
design/mesh_tile.sv
design/mesh_tile_array.sv
sim/mesh_properties.sv
sim/tb_mesh_tile_array.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f \
  --top-module tb_mesh_tile_array \
  -o tb_mesh_tile_array

./obj_dir/tb_mesh_tile_array 2>&1 | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
  echo "run_sim: PASS"
else
  echo "run_sim: FAIL"
  exit 1
fi
